// ==== logic/alu.sv ====
`timescale 1ns/100ps

module alu
    import exu_pkg::*;
(
    input  exu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [XLEN-1:0] c,
    input  logic [XLEN-1:0] d,
    output logic [XLEN-1:0] result,
    output logic            cond
);

    logic [XLEN-1:0] sum;
    logic [4:0]      shamt;

    assign sum = a + b;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = $signed(a) >>> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            // immediate arrives already shifted.
            OP_LUI:  result = b;
            OP_JALR: result = {sum[XLEN-1:1], 1'b0};
            // add, addi, address and branch target.
            default: result = sum;
        endcase
    end

    always_comb begin
        case (op)
            OP_JAL,
            OP_JALR: cond = 1'b1;
            OP_BEQ:  cond = (c == d);
            OP_BNE:  cond = (c != d);
            OP_BLT:  cond = ($signed(c) < $signed(d));
            OP_BLTU: cond = (c < d);
            default: cond = 1'b0;
        endcase
    end

endmodule

// ==== logic/exu.sv ====
`timescale 1ns/100ps

module exu
    import exu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_pc,
    input  exu_op_e               in_op,
    input  logic [REG_ADDR_W-1:0] in_rd,
    input  logic [REG_ADDR_W-1:0] in_rs1,
    input  logic [REG_ADDR_W-1:0] in_rs2,
    input  logic [XLEN-1:0]       in_imm,
    output logic                  in_ready,
    input  logic [XLEN-1:0]       src1,
    input  logic [XLEN-1:0]       src2,
    input  logic                  load_wait,
    output logic                  use_rs1,
    output logic                  use_rs2,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    input  logic                  redirect_ack,
    output logic                  ex_valid,
    output logic                  ex_we,
    output logic                  ex_is_load,
    output logic                  ex_is_store,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [XLEN-1:0]       ex_result,
    output logic [XLEN-1:0]       ex_store_data
);

    logic            is_rr;
    logic            is_branch;
    logic            is_jump;
    logic            is_load;
    logic            is_store;
    logic            pc_based;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_cond;
    logic [XLEN-1:0] pc_plus4;
    logic            accept;
    logic            take_redirect;

    assign is_rr = in_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                 OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    assign is_branch = in_op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BLTU};
    assign is_jump = in_op inside {OP_JAL, OP_JALR};
    assign is_load = (in_op == OP_LW);
    assign is_store = (in_op == OP_SW);
    assign pc_based = is_branch || (in_op == OP_JAL);

    // x0 reads never need forwarding or a stall.
    assign use_rs1 = in_valid && !(in_op inside {OP_LUI, OP_JAL}) && (in_rs1 != '0);
    assign use_rs2 = in_valid && (is_rr || is_branch || is_store) && (in_rs2 != '0);

    assign in_ready = !load_wait;
    assign accept = in_valid && in_ready;

    assign alu_a = pc_based ? in_pc : src1;
    assign alu_b = is_rr ? src2 : in_imm;
    assign pc_plus4 = in_pc + XLEN'(4);

    alu alu_inst (
        .op     (in_op),
        .a      (alu_a),
        .b      (alu_b),
        .c      (src1),
        .d      (src2),
        .result (alu_result),
        .cond   (alu_cond)
    );

    // fall-through targets need no redirect.
    assign take_redirect = accept && !redirect_valid && alu_cond && (alu_result != pc_plus4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else if (redirect_valid) begin
            redirect_valid <= !redirect_ack;
        end else begin
            redirect_valid <= take_redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (take_redirect) begin
            redirect_pc <= alu_result;
        end
    end

    // squashed or missing instructions leave a bubble.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_we <= 1'b0;
            ex_is_load <= 1'b0;
            ex_is_store <= 1'b0;
        end else begin
            ex_valid <= accept && !redirect_valid;
            if (accept) begin
                ex_we <= !(is_branch || is_store);
                ex_is_load <= is_load;
                ex_is_store <= is_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_rd <= in_rd;
            ex_result <= is_jump ? pc_plus4 : alu_result;
            ex_store_data <= src2;
        end
    end

endmodule

// ==== logic/exu_pkg.sv ====
package exu_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 4;
    localparam int NUM_REGS = 1 << REG_ADDR_W;

    // exu output, lsu stage 1 and lsu stage 2.
    localparam int BYPASS_DEPTH = 3;
    localparam int STG_EX = 0;
    localparam int STG_M1 = 1;
    localparam int STG_M2 = 2;

    // word addressed, index taken from address bits 7:2.
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_ADDI,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BLTU,
        OP_LW,
        OP_SW
    } exu_op_e;

endpackage

// ==== logic/exu_top.sv ====
`timescale 1ns/100ps

module exu_top
    import exu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_pc,
    input  exu_op_e               in_op,
    input  logic [REG_ADDR_W-1:0] in_rd,
    input  logic [REG_ADDR_W-1:0] in_rs1,
    input  logic [REG_ADDR_W-1:0] in_rs2,
    input  logic [XLEN-1:0]       in_imm,
    output logic                  in_ready,
    output logic                  redirect_valid,
    output logic [XLEN-1:0]       redirect_pc,
    input  logic                  redirect_ack,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    logic                  load_wait;
    logic                  use_rs1;
    logic                  use_rs2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;
    logic                  ex_valid;
    logic                  ex_we;
    logic                  ex_is_load;
    logic                  ex_is_store;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       ex_store_data;
    logic                  m1_valid;
    logic                  m1_we;
    logic                  m1_is_load;
    logic [REG_ADDR_W-1:0] m1_rd;
    logic [XLEN-1:0]       m1_result;
    logic                  m2_valid;
    logic                  m2_we;
    logic [REG_ADDR_W-1:0] m2_rd;
    logic [XLEN-1:0]       m2_data;

    exu exu_inst (.*);

    operand_bypass operand_bypass_inst (
        .*,
        .rs1 (in_rs1),
        .rs2 (in_rs2)
    );

    // stage 2 of the lsu owns the write port.
    regfile regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (in_rs1),
        .raddr2 (in_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    lsu lsu_inst (.*);

endmodule

// ==== logic/lsu.sv ====
`timescale 1ns/100ps

module lsu
    import exu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ex_valid,
    input  logic                  ex_we,
    input  logic                  ex_is_load,
    input  logic                  ex_is_store,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       ex_result,
    input  logic [XLEN-1:0]       ex_store_data,
    output logic                  m1_valid,
    output logic                  m1_we,
    output logic                  m1_is_load,
    output logic [REG_ADDR_W-1:0] m1_rd,
    output logic [XLEN-1:0]       m1_result,
    output logic                  m2_valid,
    output logic                  m2_we,
    output logic [REG_ADDR_W-1:0] m2_rd,
    output logic [XLEN-1:0]       m2_data,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic                   m1_is_store;
    logic [XLEN-1:0]        m1_store_data;
    logic [DMEM_ADDR_W-1:0] m1_index;
    logic                   m2_is_load;
    logic [XLEN-1:0]        m2_result;
    logic [XLEN-1:0]        ram_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m1_valid <= 1'b0;
            m1_we <= 1'b0;
            m1_is_load <= 1'b0;
            m1_is_store <= 1'b0;
            m2_valid <= 1'b0;
            m2_we <= 1'b0;
            m2_is_load <= 1'b0;
        end else begin
            m1_valid <= ex_valid;
            m1_we <= ex_we;
            m1_is_load <= ex_is_load;
            m1_is_store <= ex_is_store;
            m2_valid <= m1_valid;
            m2_we <= m1_we;
            m2_is_load <= m1_is_load;
        end
    end

    always_ff @(posedge clk) begin
        m1_rd <= ex_rd;
        m1_result <= ex_result;
        m1_store_data <= ex_store_data;
        m2_rd <= m1_rd;
        m2_result <= m1_result;
    end

    // upper address bits are ignored.
    assign m1_index = m1_result[DMEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (m1_valid && m1_is_store) begin
            dmem[m1_index] <= m1_store_data;
        end
        if (m1_valid && m1_is_load) begin
            ram_rdata <= dmem[m1_index];
        end
    end

    assign m2_data = m2_is_load ? ram_rdata : m2_result;

    assign wb_valid = m2_valid && m2_we && (m2_rd != '0);
    assign wb_rd = m2_rd;
    assign wb_data = m2_data;

endmodule

// ==== logic/operand_bypass.sv ====
`timescale 1ns/100ps

module operand_bypass
    import exu_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  use_rs1,
    input  logic                  use_rs2,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    input  logic                  ex_valid,
    input  logic                  ex_we,
    input  logic                  ex_is_load,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       ex_result,
    input  logic                  m1_valid,
    input  logic                  m1_we,
    input  logic                  m1_is_load,
    input  logic [REG_ADDR_W-1:0] m1_rd,
    input  logic [XLEN-1:0]       m1_result,
    input  logic                  m2_valid,
    input  logic                  m2_we,
    input  logic [REG_ADDR_W-1:0] m2_rd,
    input  logic [XLEN-1:0]       m2_data,
    output logic [XLEN-1:0]       src1,
    output logic [XLEN-1:0]       src2,
    output logic                  load_wait
);

    logic                  stg_hit  [BYPASS_DEPTH];
    logic [REG_ADDR_W-1:0] stg_rd   [BYPASS_DEPTH];
    logic [XLEN-1:0]       stg_data [BYPASS_DEPTH];
    logic                  stg_pend [BYPASS_DEPTH];
    logic                  src1_pend;
    logic                  src2_pend;

    always_comb begin
        stg_hit[STG_EX] = ex_valid && ex_we;
        stg_rd[STG_EX] = ex_rd;
        stg_data[STG_EX] = ex_result;
        stg_pend[STG_EX] = ex_is_load;
        stg_hit[STG_M1] = m1_valid && m1_we;
        stg_rd[STG_M1] = m1_rd;
        stg_data[STG_M1] = m1_result;
        stg_pend[STG_M1] = m1_is_load;
        // load data is back from the ram by stage 2.
        stg_hit[STG_M2] = m2_valid && m2_we;
        stg_rd[STG_M2] = m2_rd;
        stg_data[STG_M2] = m2_data;
        stg_pend[STG_M2] = 1'b0;
    end

    // oldest first, so the youngest match overrides.
    always_comb begin
        src1 = rf_rdata1;
        src2 = rf_rdata2;
        src1_pend = 1'b0;
        src2_pend = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (stg_hit[i] && (stg_rd[i] == rs1) && (rs1 != '0)) begin
                src1 = stg_data[i];
                src1_pend = stg_pend[i];
            end
            if (stg_hit[i] && (stg_rd[i] == rs2) && (rs2 != '0)) begin
                src2 = stg_data[i];
                src2_pend = stg_pend[i];
            end
        end
    end

    assign load_wait = (use_rs1 && src1_pend) || (use_rs2 && src2_pend);

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/100ps

module regfile
    import exu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 is cleared by reset and never written.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== project.f ====
+incdir+test
logic/exu_pkg.sv
logic/alu.sv
logic/operand_bypass.sv
logic/regfile.sv
logic/exu.sv
logic/lsu.sv
logic/exu_top.sv
test/exu_tb.sv

// ==== test/exu_ref_model.svh ====
// architectural state of the program as issued.
logic [XLEN-1:0]       model_regs [NUM_REGS];
logic [XLEN-1:0]       model_mem [DMEM_WORDS];
logic [XLEN-1:0]       model_pc;
logic                  model_pending;
logic [XLEN-1:0]       model_target;
int                    model_wb_count;

// expected writebacks, oldest first.
logic [REG_ADDR_W-1:0] exp_rd_q [$];
logic [XLEN-1:0]       exp_data_q [$];
int                    exp_cyc_q [$];

task automatic reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        model_mem[i] = '0;
    end
    model_pc = 32'h0000_0100;
    model_pending = 1'b0;
    model_target = '0;
    model_wb_count = 0;
    exp_rd_q.delete();
    exp_data_q.delete();
    exp_cyc_q.delete();
endtask

// one accepted, live instruction in program order.
task automatic execute_model(exu_op_e op, logic [REG_ADDR_W-1:0] rd,
                             logic [REG_ADDR_W-1:0] rs1, logic [REG_ADDR_W-1:0] rs2,
                             logic [XLEN-1:0] imm, int wb_cyc, output logic redirect);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] val;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] addr;
    logic            writes;
    logic            taken;
    a = model_regs[rs1];
    b = model_regs[rs2];
    next_pc = model_pc + 32'd4;
    target = model_pc + imm;
    addr = a + imm;
    val = '0;
    writes = 1'b1;
    taken = 1'b0;
    case (op)
        OP_ADD:  val = a + b;
        OP_SUB:  val = a - b;
        OP_AND:  val = a & b;
        OP_OR:   val = a | b;
        OP_XOR:  val = a ^ b;
        OP_SLL:  val = a << b[4:0];
        OP_SRL:  val = a >> b[4:0];
        OP_SRA:  val = $signed(a) >>> b[4:0];
        OP_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU: val = (a < b) ? 32'd1 : 32'd0;
        OP_LUI:  val = imm;
        OP_ADDI: val = a + imm;
        OP_JAL: begin
            val = next_pc;
            taken = 1'b1;
        end
        OP_JALR: begin
            val = next_pc;
            target = addr & ~32'd1;
            taken = 1'b1;
        end
        OP_LW:   val = model_mem[addr[7:2]];
        OP_SW: begin
            writes = 1'b0;
            model_mem[addr[7:2]] = b;
        end
        default: begin
            writes = 1'b0;
            case (op)
                OP_BEQ:  taken = (a == b);
                OP_BNE:  taken = (a != b);
                OP_BLT:  taken = ($signed(a) < $signed(b));
                default: taken = (a < b);
            endcase
        end
    endcase
    if (writes && (rd != '0)) begin
        model_regs[rd] = val;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(val);
        exp_cyc_q.push_back(wb_cyc);
        model_wb_count++;
    end
    redirect = taken && (target != next_pc);
    if (redirect) begin
        model_pending = 1'b1;
        model_target = target;
        model_pc = target;
    end else begin
        model_pc = next_pc;
    end
endtask

// ==== test/exu_tb.sv ====
`timescale 1ns/100ps

module exu_tb
    import exu_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int STALL_LIMIT = 2;
    localparam int DRAIN_LIMIT = 20;
    localparam int RUN_LIMIT = 40000;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic [XLEN-1:0]       in_pc;
    exu_op_e               in_op;
    logic [REG_ADDR_W-1:0] in_rd;
    logic [REG_ADDR_W-1:0] in_rs1;
    logic [REG_ADDR_W-1:0] in_rs2;
    logic [XLEN-1:0]       in_imm;
    logic                  in_ready;
    logic                  redirect_valid;
    logic [XLEN-1:0]       redirect_pc;
    logic                  redirect_ack;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    integer                seed;
    int                    cyc;
    logic                  s_ready;
    logic                  s_rv;
    logic [XLEN-1:0]       s_rpc;
    logic                  s_wb;
    int                    errors;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;
    int                    wb_count;
    string                 cur_test;
    bit                    stuck;

    `include "exu_ref_model.svh"

    exu_top exu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("TEST FAIL");
        $finish;
    end

    task automatic check(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_failure(string msg);
        $display("%s: %s", cur_test, msg);
        errors++;
        test_errors++;
    endtask

    // outputs are sampled mid-cycle, where they are settled.
    always @(negedge clk) begin
        cyc++;
        s_ready = in_ready;
        s_rv = redirect_valid;
        s_rpc = redirect_pc;
        s_wb = wb_valid;
        if (rst === 1'b0) begin
            if (wb_valid === 1'b1) begin
                wb_count++;
                if (exp_rd_q.size() == 0) begin
                    report_failure("writeback seen with no instruction expecting one");
                end else begin
                    check("wb_rd", exp_rd_q[0], wb_rd);
                    check("wb_data", exp_data_q[0], wb_data);
                    check("wb cycle", exp_cyc_q[0], cyc);
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end else if (wb_valid !== 1'b0) begin
                report_failure("wb_valid is unknown");
            end else if ((exp_cyc_q.size() != 0) && (exp_cyc_q[0] <= cyc)) begin
                report_failure("an expected writeback did not appear");
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
    end

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // mostly a few low registers, so hazards are common.
    function automatic logic [REG_ADDR_W-1:0] pick_reg();
        if (rand_below(4) != 0) begin
            return REG_ADDR_W'(rand_below(6));
        end
        return REG_ADDR_W'(rand_below(NUM_REGS));
    endfunction

    function automatic exu_op_e alu_op();
        return exu_op_e'(rand_below(12));
    endfunction

    function automatic exu_op_e any_op();
        return exu_op_e'(rand_below(20));
    endfunction

    task automatic present(exu_op_e op, logic [REG_ADDR_W-1:0] rd,
                           logic [REG_ADDR_W-1:0] rs1, logic [REG_ADDR_W-1:0] rs2,
                           logic [XLEN-1:0] imm);
        in_valid <= 1'b1;
        in_pc <= model_pc;
        in_op <= op;
        in_rd <= rd;
        in_rs1 <= rs1;
        in_rs2 <= rs2;
        in_imm <= imm;
    endtask

    // returns on the accepting edge, inputs still held.
    task automatic issue(exu_op_e op, logic [REG_ADDR_W-1:0] rd,
                         logic [REG_ADDR_W-1:0] rs1, logic [REG_ADDR_W-1:0] rs2,
                         logic [XLEN-1:0] imm, output logic redirect);
        int waits;
        redirect = 1'b0;
        waits = 0;
        if (!stuck) begin
            present(op, rd, rs1, rs2, imm);
            @(posedge clk);
            while ((s_ready !== 1'b1) && !stuck) begin
                waits++;
                if (waits > STALL_LIMIT) begin
                    report_failure("in_ready stayed low longer than a load-use stall");
                    stuck = 1'b1;
                end else begin
                    @(posedge clk);
                end
            end
            if (!stuck) begin
                check("redirect_valid at accept", model_pending, s_rv);
                if (!model_pending) begin
                    execute_model(op, rd, rs1, rs2, imm, cyc + 3, redirect);
                end
            end
        end
    endtask

    task automatic issue_op(exu_op_e op, logic [REG_ADDR_W-1:0] rd,
                            logic [REG_ADDR_W-1:0] rs1, logic [REG_ADDR_W-1:0] rs2,
                            output logic redirect);
        logic [XLEN-1:0] imm;
        int              word;
        imm = $random(seed);
        word = (rand_below(4) == 0) ? rand_below(DMEM_WORDS) : rand_below(4);
        case (op)
            OP_ADDI: imm = {{20{imm[11]}}, imm[11:0]};
            OP_LUI:  imm = {imm[31:12], 12'h000};
            OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BLTU: imm = (rand_below(6) - 2) * 4;
            // aim jalr at a nearby aligned pc.
            OP_JALR: imm = model_pc + (rand_below(6) - 2) * 4 - model_regs[rs1];
            OP_LW, OP_SW: imm = word * 4 - model_regs[rs1];
            default: ;
        endcase
        issue(op, rd, rs1, rs2, imm, redirect);
    endtask

    task automatic follow_redirect();
        int      fillers;
        logic    dummy;
        exu_op_e op;
        fillers = rand_below(4);
        in_valid <= 1'b0;
        @(posedge clk);
        check("redirect_valid", 1'b1, s_rv);
        check("redirect_pc", model_target, s_rpc);
        for (int i = 0; i < fillers; i++) begin
            // stores often, so a leaked store shows up in the ram.
            op = (rand_below(2) == 0) ? OP_SW : any_op();
            issue_op(op, pick_reg(), pick_reg(), pick_reg(), dummy);
        end
        in_valid <= 1'b0;
        redirect_ack <= 1'b1;
        @(posedge clk);
        redirect_ack <= 1'b0;
        model_pending = 1'b0;
    endtask

    task automatic run_op(exu_op_e op, logic [REG_ADDR_W-1:0] rd,
                          logic [REG_ADDR_W-1:0] rs1, logic [REG_ADDR_W-1:0] rs2);
        logic redirect;
        issue_op(op, rd, rs1, rs2, redirect);
        if (redirect) begin
            follow_redirect();
        end
    endtask

    task automatic start_test(string name);
        cur_test = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test();
        int waits;
        waits = 0;
        in_valid <= 1'b0;
        @(posedge clk);
        while ((exp_rd_q.size() != 0) && (waits < DRAIN_LIMIT)) begin
            waits++;
            @(posedge clk);
        end
        if (exp_rd_q.size() != 0) begin
            report_failure("writebacks still outstanding at end of test");
        end
        // idle a little longer to catch stray writebacks.
        repeat (4) @(posedge clk);
        check("writeback count", model_wb_count, wb_count);
        if (test_errors == 0) begin
            $display("[%0s] ok", cur_test);
        end else begin
            $display("[%0s] failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    task automatic reset_and_alu_ops();
        start_test("reset_alu");
        in_valid <= 1'b0;
        @(posedge clk);
        check("in_ready after reset", 1'b1, s_ready);
        check("redirect_valid after reset", 1'b0, s_rv);
        check("wb_valid after reset", 1'b0, s_wb);
        for (int i = 0; i < 8; i++) begin
            run_op((i % 2) ? OP_ADDI : OP_LUI, REG_ADDR_W'(i + 1), '0, '0);
        end
        for (int i = 0; i < 16; i++) begin
            run_op(alu_op(), pick_reg(), pick_reg(), pick_reg());
        end
        finish_test();
    endtask

    task automatic forwarding_chains();
        logic [REG_ADDR_W-1:0] hist [3];
        logic [REG_ADDR_W-1:0] rd;
        start_test("forwarding");
        hist = '{4'd1, 4'd2, 4'd3};
        for (int i = 0; i < 60; i++) begin
            // x0 now and then, so its writes get dropped.
            rd = (rand_below(8) == 0) ? '0 : REG_ADDR_W'(1 + rand_below(3));
            run_op(alu_op(), rd, hist[0], hist[rand_below(3)]);
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
        finish_test();
    endtask

    task automatic load_use_pairs();
        logic [REG_ADDR_W-1:0] rd;
        logic                  redirect;
        start_test("load_use");
        // fill every word of the data ram first.
        for (int i = 0; i < DMEM_WORDS; i++) begin
            issue(OP_ADDI, 4'd7, '0, '0, $random(seed), redirect);
            issue(OP_SW, '0, '0, 4'd7, i * 4, redirect);
        end
        for (int i = 0; i < 40; i++) begin
            rd = REG_ADDR_W'(1 + rand_below(5));
            run_op(OP_LW, rd, pick_reg(), pick_reg());
            if (rand_below(2) == 0) begin
                run_op(alu_op(), pick_reg(), rd, pick_reg());
            end else begin
                run_op(alu_op(), pick_reg(), pick_reg(), rd);
            end
        end
        finish_test();
    endtask

    task automatic stores_and_loads();
        start_test("store_load");
        for (int i = 0; i < 60; i++) begin
            case (rand_below(3))
                0:       run_op(OP_SW, '0, pick_reg(), pick_reg());
                1:       run_op(OP_LW, pick_reg(), pick_reg(), pick_reg());
                default: run_op(OP_ADDI, pick_reg(), pick_reg(), pick_reg());
            endcase
        end
        finish_test();
    endtask

    task automatic redirect_flow();
        exu_op_e op;
        logic    redirect;
        start_test("redirects");
        for (int i = 0; i < 50; i++) begin
            case (rand_below(7))
                0:       op = OP_JAL;
                1:       op = OP_JALR;
                2:       op = OP_BEQ;
                3:       op = OP_BNE;
                4:       op = OP_BLT;
                5:       op = OP_BLTU;
                default: op = OP_ADDI;
            endcase
            run_op(op, pick_reg(), pick_reg(), pick_reg());
        end
        // squashed filler stores must leave the data ram untouched.
        for (int i = 0; i < DMEM_WORDS; i++) begin
            issue(OP_LW, 4'd1, '0, '0, i * 4, redirect);
        end
        finish_test();
    endtask

    task automatic random_program();
        logic redirect;
        start_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            run_op(any_op(), pick_reg(), pick_reg(), pick_reg());
        end
        // read out every register, then every data word.
        for (int r = 1; r < NUM_REGS; r++) begin
            issue(OP_ADD, REG_ADDR_W'(r), REG_ADDR_W'(r), '0, '0, redirect);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            issue(OP_LW, 4'd1, '0, '0, i * 4, redirect);
        end
        finish_test();
    endtask

    initial begin
        seed = 32'hce9d_12fb;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        wb_count = 0;
        stuck = 1'b0;
        cur_test = "reset";
        in_valid = 1'b0;
        in_pc = '0;
        in_op = OP_ADD;
        in_rd = '0;
        in_rs1 = '0;
        in_rs2 = '0;
        in_imm = '0;
        redirect_ack = 1'b0;
        rst = 1'b1;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_and_alu_ops();
        forwarding_chains();
        load_use_pairs();
        stores_and_loads();
        redirect_flow();
        random_program();
        $display("tests %0d, failed %0d, errors %0d, writebacks %0d of %0d expected",
                 tests_run, tests_failed, errors, wb_count, model_wb_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
